// File: hw/core_pkg.sv
package core_pkg;

    localparam int XLEN   = 32;
    localparam int NREGS  = 32;
    localparam int REG_AW = 5;
    localparam int GP_REG = 3;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // major opcodes, RISC-V encodings
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // owner of the shared memory port
    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_FETCH,
        GNT_DATA
    } grant_e;

endpackage

// File: hw/reg_file.sv
`timescale 1ns/1ns

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  logic      wb_valid_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    output word_t     gp_o
);

    word_t regs [NREGS];
    logic  wr_en;

    // x0 is never written
    assign wr_en = wb_valid_i && wb_we_i && (wb_rd_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // write-through stands in for forwarding
    assign rs1_data_o = (wr_en && wb_rd_i == rs1_addr_i) ? wb_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (wr_en && wb_rd_i == rs2_addr_i) ? wb_data_i : regs[rs2_addr_i];
    assign gp_o       = regs[GP_REG];

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit import core_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  fetch_gnt_i,
    input  logic  fetch_rvalid_i,
    input  word_t fetch_rdata_i,
    input  logic  stall_i,
    input  logic  flush_i,
    input  word_t redirect_pc_i,
    input  logic  halt_i,
    output logic  fetch_req_o,
    output word_t fetch_addr_o,
    output logic  id_valid_o,
    output word_t id_pc_o,
    output word_t id_inst_o
);

    word_t pc;
    logic  fetch_en;
    logic  pending;
    logic  stale;
    logic  accept;

    // a response dropped while ID holds is simply fetched again from the same pc
    assign accept       = fetch_rvalid_i && !stale && !flush_i && !stall_i;
    assign fetch_req_o  = fetch_en && !pending && !halt_i;
    assign fetch_addr_o = pc;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_en   <= 1'b0;
            pending    <= 1'b0;
            stale      <= 1'b0;
            pc         <= RESET_PC;
            id_valid_o <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (fetch_gnt_i)
                pending <= 1'b1;
            else if (fetch_rvalid_i)
                pending <= 1'b0;
            // redirect while a fetch is in flight
            if (fetch_rvalid_i)
                stale <= 1'b0;
            else if (flush_i && (pending || fetch_gnt_i))
                stale <= 1'b1;
            if (flush_i)
                pc <= redirect_pc_i;
            else if (accept)
                pc <= pc + 32'd4;
            if (flush_i)
                id_valid_o <= 1'b0;
            else if (!stall_i)
                id_valid_o <= fetch_rvalid_i && !stale;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_pc_o   <= pc;
            id_inst_o <= fetch_rdata_i;
        end
    end

    // exit latch is sticky, fetch stays quiet from then on
    assert property (@(posedge clk) disable iff (!arst_n_i) halt_i |=> !fetch_req_o);

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      id_valid_i,
    input  word_t     id_pc_i,
    input  word_t     id_inst_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  logic      stall_i,
    input  logic      stall_ex_i,
    input  logic      flush_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      ex_valid_o,
    output word_t     ex_pc_o,
    output opcode_e   ex_opcode_o,
    output alu_op_e   ex_alu_op_o,
    output word_t     ex_op1_o,
    output word_t     ex_op2_o,
    output word_t     ex_rs2_data_o,
    output word_t     ex_imm_o,
    output reg_addr_t ex_rd_o,
    output logic      ex_rf_we_o,
    output logic      ex_branch_ne_o
);

    logic [2:0] funct3;
    word_t      imm_i, imm_s, imm_b, imm_j, imm;
    opcode_e    opcode;
    alu_op_e    alu_op, f3_op;
    logic       f3_ok, rf_we, use_rs1, use_rs2, op2_imm;

    assign funct3 = id_inst_i[14:12];
    assign imm_i  = {{20{id_inst_i[31]}}, id_inst_i[31:20]};
    assign imm_s  = {{20{id_inst_i[31]}}, id_inst_i[31:25], id_inst_i[11:7]};
    assign imm_b  = {{20{id_inst_i[31]}}, id_inst_i[7], id_inst_i[30:25],
                     id_inst_i[11:8], 1'b0};
    assign imm_j  = {{12{id_inst_i[31]}}, id_inst_i[19:12], id_inst_i[20],
                     id_inst_i[30:21], 1'b0};

    always_comb begin
        f3_ok = 1'b1;
        f3_op = ALU_ADD;
        case (funct3)
            3'b000:  f3_op = (id_inst_i[6:0] == OPC_OP && id_inst_i[30]) ? ALU_SUB : ALU_ADD;
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: f3_ok = 1'b0;
        endcase
    end

    // anything not recognised leaves the defaults, an ADDI that writes nothing
    always_comb begin
        opcode  = OPC_OP_IMM;
        alu_op  = ALU_ADD;
        imm     = imm_i;
        rf_we   = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        op2_imm = 1'b1;
        case (id_inst_i[6:0])
            OPC_OP_IMM: if (f3_ok) begin
                alu_op  = f3_op;
                rf_we   = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_OP: if (f3_ok) begin
                opcode  = OPC_OP;
                alu_op  = f3_op;
                rf_we   = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                op2_imm = 1'b0;
            end
            OPC_LOAD: if (funct3 == 3'b010) begin
                opcode  = OPC_LOAD;
                rf_we   = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_STORE: if (funct3 == 3'b010) begin
                opcode  = OPC_STORE;
                imm     = imm_s;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_BRANCH: if (funct3[2:1] == 2'b00) begin
                opcode  = OPC_BRANCH;
                imm     = imm_b;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                op2_imm = 1'b0;
            end
            OPC_JAL: begin
                opcode = OPC_JAL;
                imm    = imm_j;
                rf_we  = 1'b1;
            end
            OPC_SYSTEM: if (id_inst_i == 32'h0000_0073)
                opcode = OPC_SYSTEM;
            default: ;
        endcase
    end

    // unused source fields read as x0 so they never trip the interlock
    assign rs1_addr_o = use_rs1 ? id_inst_i[19:15] : '0;
    assign rs2_addr_o = use_rs2 ? id_inst_i[24:20] : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            ex_valid_o <= 1'b0;
        else if (flush_i)
            ex_valid_o <= 1'b0;
        else if (!stall_ex_i)
            ex_valid_o <= id_valid_i && !stall_i;
    end

    always_ff @(posedge clk) begin
        if (!stall_ex_i) begin
            ex_pc_o        <= id_pc_i;
            ex_opcode_o    <= opcode;
            ex_alu_op_o    <= alu_op;
            ex_op1_o       <= rs1_data_i;
            ex_op2_o       <= op2_imm ? imm : rs2_data_i;
            ex_rs2_data_o  <= rs2_data_i;
            ex_imm_o       <= imm;
            ex_rd_o        <= id_inst_i[11:7];
            ex_rf_we_o     <= rf_we;
            ex_branch_ne_o <= funct3[0];
        end
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      ex_valid_i,
    input  word_t     ex_pc_i,
    input  opcode_e   ex_opcode_i,
    input  alu_op_e   ex_alu_op_i,
    input  word_t     ex_op1_i,
    input  word_t     ex_op2_i,
    input  word_t     ex_rs2_data_i,
    input  word_t     ex_imm_i,
    input  reg_addr_t ex_rd_i,
    input  logic      ex_rf_we_i,
    input  logic      ex_branch_ne_i,
    input  logic      stall_i,
    output logic      redirect_o,
    output word_t     target_o,
    output logic      mem_valid_o,
    output opcode_e   mem_opcode_o,
    output word_t     mem_result_o,
    output word_t     mem_store_data_o,
    output reg_addr_t mem_rd_o,
    output logic      mem_rf_we_o
);

    word_t alu_out;
    logic  taken;

    always_comb begin
        case (ex_alu_op_i)
            ALU_SUB: alu_out = ex_op1_i - ex_op2_i;
            ALU_AND: alu_out = ex_op1_i & ex_op2_i;
            ALU_OR:  alu_out = ex_op1_i | ex_op2_i;
            ALU_XOR: alu_out = ex_op1_i ^ ex_op2_i;
            ALU_SLT: alu_out = word_t'($signed(ex_op1_i) < $signed(ex_op2_i));
            default: alu_out = ex_op1_i + ex_op2_i;
        endcase
    end

    // branches carry rs2 in op2
    assign taken = (ex_opcode_i == OPC_JAL) ||
                   (ex_opcode_i == OPC_BRANCH && ((ex_op1_i == ex_op2_i) ^ ex_branch_ne_i));

    assign redirect_o = ex_valid_i && !stall_i && taken;
    assign target_o   = ex_pc_i + ex_imm_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            mem_valid_o <= 1'b0;
        else if (!stall_i)
            mem_valid_o <= ex_valid_i;
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            mem_opcode_o     <= ex_opcode_i;
            mem_result_o     <= (ex_opcode_i == OPC_JAL) ? ex_pc_i + 32'd4 : alu_out;
            mem_store_data_o <= ex_rs2_data_i;
            mem_rd_o         <= ex_rd_i;
            mem_rf_we_o      <= ex_rf_we_i;
        end
    end

endmodule

// File: hw/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      mem_valid_i,
    input  opcode_e   mem_opcode_i,
    input  word_t     mem_result_i,
    input  word_t     mem_store_data_i,
    input  reg_addr_t mem_rd_i,
    input  logic      mem_rf_we_i,
    input  logic      data_gnt_i,
    input  logic      data_rvalid_i,
    input  word_t     data_rdata_i,
    output logic      data_req_o,
    output logic      data_we_o,
    output word_t     data_addr_o,
    output word_t     data_wdata_o,
    output logic      busy_o,
    output logic      wb_valid_o,
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o,
    output logic      wb_exit_o
);

    logic is_load, is_store;
    logic wait_resp;

    assign is_load  = mem_valid_i && mem_opcode_i == OPC_LOAD;
    assign is_store = mem_valid_i && mem_opcode_i == OPC_STORE;

    assign data_req_o   = (is_load || is_store) && !wait_resp;
    assign data_we_o    = is_store;
    assign data_addr_o  = mem_result_i;
    assign data_wdata_o = mem_store_data_i;

    // store leaves on its grant, load on its response
    assign busy_o = (is_store && !data_gnt_i) || (is_load && !data_rvalid_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_resp  <= 1'b0;
            wb_valid_o <= 1'b0;
        end else begin
            if (is_load && data_gnt_i)
                wait_resp <= 1'b1;
            else if (data_rvalid_i)
                wait_resp <= 1'b0;
            wb_valid_o <= mem_valid_i && !busy_o;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid_i && !busy_o) begin
            wb_we_o   <= mem_rf_we_i;
            wb_rd_o   <= mem_rd_i;
            wb_data_o <= is_load ? data_rdata_i : mem_result_i;
            wb_exit_o <= mem_opcode_i == OPC_SYSTEM;
        end
    end

    // a granted load blocks the port until its data is back
    assert property (@(posedge clk) disable iff (!arst_n_i)
        data_gnt_i && !data_we_o |=> !data_req_o);

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter import core_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  fetch_req_i,
    input  word_t fetch_addr_i,
    input  logic  data_req_i,
    input  logic  data_we_i,
    input  word_t data_addr_i,
    input  word_t data_wdata_i,
    input  word_t mem_rdata_i,
    output logic  fetch_gnt_o,
    output logic  data_gnt_o,
    output logic  fetch_rvalid_o,
    output logic  data_rvalid_o,
    output word_t rdata_o,
    output logic  mem_req_o,
    output logic  mem_we_o,
    output word_t mem_addr_o,
    output word_t mem_wdata_o
);

    grant_e owner;

    // data always wins
    assign data_gnt_o  = data_req_i;
    assign fetch_gnt_o = fetch_req_i && !data_req_i;

    assign mem_req_o   = data_req_i || fetch_req_i;
    assign mem_we_o    = data_req_i && data_we_i;
    assign mem_addr_o  = data_req_i ? data_addr_i : fetch_addr_i;
    assign mem_wdata_o = data_wdata_i;

    // stores get no response
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            owner <= GNT_NONE;
        else if (data_gnt_o)
            owner <= data_we_i ? GNT_NONE : GNT_DATA;
        else if (fetch_gnt_o)
            owner <= GNT_FETCH;
        else
            owner <= GNT_NONE;
    end

    assign fetch_rvalid_o = owner == GNT_FETCH;
    assign data_rvalid_o  = owner == GNT_DATA;
    assign rdata_o        = mem_rdata_i;

    assert property (@(posedge clk) disable iff (!arst_n_i) !(fetch_gnt_o && data_gnt_o));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_rvalid_o |-> $past(fetch_gnt_o));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        data_rvalid_o |-> $past(data_gnt_o));

endmodule

// File: hw/pipeline_ctrl.sv
`timescale 1ns/1ns

module pipeline_ctrl import core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  logic      id_valid_i,
    input  logic      ex_valid_i,
    input  reg_addr_t ex_rd_i,
    input  logic      ex_rf_we_i,
    input  logic      mem_valid_i,
    input  reg_addr_t mem_rd_i,
    input  logic      mem_rf_we_i,
    input  logic      lsu_busy_i,
    input  logic      redirect_i,
    input  logic      wb_valid_i,
    input  logic      wb_exit_i,
    output logic      stall_id_o,
    output logic      stall_ex_o,
    output logic      stall_mem_o,
    output logic      flush_o,
    output logic      exit_o
);

    logic ex_wr, mem_wr;
    logic hit_rs1, hit_rs2;

    assign ex_wr  = ex_valid_i && ex_rf_we_i;
    assign mem_wr = mem_valid_i && mem_rf_we_i;

    // no forwarding, so wait until the producer reaches WB
    assign hit_rs1 = (rs1_addr_i != '0) &&
                     ((ex_wr && ex_rd_i == rs1_addr_i) || (mem_wr && mem_rd_i == rs1_addr_i));
    assign hit_rs2 = (rs2_addr_i != '0) &&
                     ((ex_wr && ex_rd_i == rs2_addr_i) || (mem_wr && mem_rd_i == rs2_addr_i));

    assign stall_mem_o = lsu_busy_i;
    assign stall_ex_o  = lsu_busy_i;
    assign stall_id_o  = lsu_busy_i || (id_valid_i && (hit_rs1 || hit_rs2));
    assign flush_o     = redirect_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            exit_o <= 1'b0;
        else if (wb_valid_i && wb_exit_i)
            exit_o <= 1'b1;
    end

    // execute holds its redirect while memory back-pressure is on
    assert property (@(posedge clk) disable iff (!arst_n_i) flush_o |-> !stall_ex_o);

endmodule

// File: hw/core_top.sv
`timescale 1ns/1ns

module core_top import core_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  word_t mem_rdata_i,
    output logic  mem_req_o,
    output logic  mem_we_o,
    output word_t mem_addr_o,
    output word_t mem_wdata_o,
    output logic  exit_o,
    output word_t gp_o
);

    logic      fetch_req, fetch_gnt, fetch_rvalid;
    word_t     fetch_addr, rdata;
    logic      data_req, data_we, data_gnt, data_rvalid;
    word_t     data_addr, data_wdata;
    logic      stall_id, stall_ex, stall_mem, flush, redirect, lsu_busy;
    word_t     target;
    logic      id_valid;
    word_t     id_pc, id_inst;
    reg_addr_t rs1_addr, rs2_addr;
    word_t     rs1_data, rs2_data;
    logic      ex_valid, ex_rf_we, ex_branch_ne;
    opcode_e   ex_opcode;
    alu_op_e   ex_alu_op;
    word_t     ex_pc, ex_op1, ex_op2, ex_rs2_data, ex_imm;
    reg_addr_t ex_rd;
    logic      mem_valid, mem_rf_we;
    opcode_e   mem_opcode;
    word_t     mem_result, mem_store_data;
    reg_addr_t mem_rd;
    logic      wb_valid, wb_we, wb_exit;
    reg_addr_t wb_rd;
    word_t     wb_data;

    fetch_unit u_fetch_unit (
        .clk(clk), .arst_n_i(arst_n_i),
        .fetch_gnt_i(fetch_gnt), .fetch_rvalid_i(fetch_rvalid), .fetch_rdata_i(rdata),
        .stall_i(stall_id), .flush_i(flush), .redirect_pc_i(target), .halt_i(exit_o),
        .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
        .id_valid_o(id_valid), .id_pc_o(id_pc), .id_inst_o(id_inst)
    );

    decode_stage u_decode_stage (
        .clk(clk), .arst_n_i(arst_n_i),
        .id_valid_i(id_valid), .id_pc_i(id_pc), .id_inst_i(id_inst),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .stall_i(stall_id), .stall_ex_i(stall_ex), .flush_i(flush),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .ex_valid_o(ex_valid), .ex_pc_o(ex_pc), .ex_opcode_o(ex_opcode),
        .ex_alu_op_o(ex_alu_op), .ex_op1_o(ex_op1), .ex_op2_o(ex_op2),
        .ex_rs2_data_o(ex_rs2_data), .ex_imm_o(ex_imm), .ex_rd_o(ex_rd),
        .ex_rf_we_o(ex_rf_we), .ex_branch_ne_o(ex_branch_ne)
    );

    reg_file u_reg_file (
        .clk(clk), .arst_n_i(arst_n_i),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .wb_valid_i(wb_valid), .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .gp_o(gp_o)
    );

    execute_stage u_execute_stage (
        .clk(clk), .arst_n_i(arst_n_i),
        .ex_valid_i(ex_valid), .ex_pc_i(ex_pc), .ex_opcode_i(ex_opcode),
        .ex_alu_op_i(ex_alu_op), .ex_op1_i(ex_op1), .ex_op2_i(ex_op2),
        .ex_rs2_data_i(ex_rs2_data), .ex_imm_i(ex_imm), .ex_rd_i(ex_rd),
        .ex_rf_we_i(ex_rf_we), .ex_branch_ne_i(ex_branch_ne), .stall_i(stall_mem),
        .redirect_o(redirect), .target_o(target),
        .mem_valid_o(mem_valid), .mem_opcode_o(mem_opcode), .mem_result_o(mem_result),
        .mem_store_data_o(mem_store_data), .mem_rd_o(mem_rd), .mem_rf_we_o(mem_rf_we)
    );

    load_store_unit u_load_store_unit (
        .clk(clk), .arst_n_i(arst_n_i),
        .mem_valid_i(mem_valid), .mem_opcode_i(mem_opcode), .mem_result_i(mem_result),
        .mem_store_data_i(mem_store_data), .mem_rd_i(mem_rd), .mem_rf_we_i(mem_rf_we),
        .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid), .data_rdata_i(rdata),
        .data_req_o(data_req), .data_we_o(data_we), .data_addr_o(data_addr),
        .data_wdata_o(data_wdata), .busy_o(lsu_busy),
        .wb_valid_o(wb_valid), .wb_we_o(wb_we), .wb_rd_o(wb_rd),
        .wb_data_o(wb_data), .wb_exit_o(wb_exit)
    );

    mem_arbiter u_mem_arbiter (
        .clk(clk), .arst_n_i(arst_n_i),
        .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
        .data_req_i(data_req), .data_we_i(data_we), .data_addr_i(data_addr),
        .data_wdata_i(data_wdata), .mem_rdata_i(mem_rdata_i),
        .fetch_gnt_o(fetch_gnt), .data_gnt_o(data_gnt),
        .fetch_rvalid_o(fetch_rvalid), .data_rvalid_o(data_rvalid), .rdata_o(rdata),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o)
    );

    pipeline_ctrl u_pipeline_ctrl (
        .clk(clk), .arst_n_i(arst_n_i),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .id_valid_i(id_valid),
        .ex_valid_i(ex_valid), .ex_rd_i(ex_rd), .ex_rf_we_i(ex_rf_we),
        .mem_valid_i(mem_valid), .mem_rd_i(mem_rd), .mem_rf_we_i(mem_rf_we),
        .lsu_busy_i(lsu_busy), .redirect_i(redirect),
        .wb_valid_i(wb_valid), .wb_exit_i(wb_exit),
        .stall_id_o(stall_id), .stall_ex_o(stall_ex), .stall_mem_o(stall_mem),
        .flush_o(flush), .exit_o(exit_o)
    );

endmodule

// File: bench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program image built by the tests, one instruction word per entry
word_t prog[$];

function automatic word_t enc_r(word_t f7, word_t rs2, word_t rs1, word_t f3, word_t rd,
                                word_t opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic word_t enc_i(word_t imm, word_t rs1, word_t f3, word_t rd, word_t opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic word_t enc_s(word_t imm, word_t rs2, word_t rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

// byte offset relative to the branch itself
function automatic word_t enc_b(word_t imm, word_t rs2, word_t rs1, word_t f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'b1100011};
endfunction

function automatic word_t enc_j(word_t imm, word_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

function automatic word_t addi(int rd, int rs1, int imm);
    return enc_i(imm, rs1, 0, rd, 7'b0010011);
endfunction

function automatic word_t alu_r(int f7, int f3, int rd, int rs1, int rs2);
    return enc_r(f7, rs2, rs1, f3, rd, 7'b0110011);
endfunction

function automatic word_t lw(int rd, int rs1, int imm);
    return enc_i(imm, rs1, 2, rd, 7'b0000011);
endfunction

function automatic word_t sw(int rs2, int rs1, int imm);
    return enc_s(imm, rs2, rs1);
endfunction

function automatic word_t ecall();
    return 32'h0000_0073;
endfunction

// append an instruction, then some NOPs behind it
task automatic emit(word_t inst, int gap);
    prog.push_back(inst);
    for (int i = 0; i < gap; i++)
        prog.push_back(addi(0, 0, 0));
endtask

// every word becomes an ADDI to x0 whose immediate is its own index
task automatic load_program();
    for (int i = 0; i < 1024; i++)
        mem[i] = addi(0, 0, i);
    for (int i = 0; i < prog.size(); i++)
        mem[i] = prog[i];
endtask

`endif

// File: bench/tb_core_top.sv
`timescale 1ns/1ns

module tb_core_top import core_pkg::*; ();

    logic  clk;
    logic  arst_n_i;
    word_t mem_rdata_i;
    logic  mem_req_o, mem_we_o, exit_o;
    word_t mem_addr_o, mem_wdata_o, gp_o;
    word_t mem [1024];
    int    errors;
    int    checks;

    `include "tb_program.svh"

    core_top u_core_top (
        .clk(clk), .arst_n_i(arst_n_i), .mem_rdata_i(mem_rdata_i),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .exit_o(exit_o), .gp_o(gp_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // single-port memory answering one cycle after the request
    always @(posedge clk) begin
        word_t rd;
        rd = mem[mem_addr_o[11:2]];
        if (mem_req_o && mem_we_o)
            mem[mem_addr_o[11:2]] = mem_wdata_o;
        #2 mem_rdata_i = rd;
    end

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    function automatic word_t rand_imm();
        word_t r;
        r = $urandom;
        return {{20{r[11]}}, r[11:0]};
    endfunction

    task automatic pulse_reset();
        @(posedge clk);
        #2 arst_n_i = 1'b0;
        repeat (2) @(posedge clk);
        #2 arst_n_i = 1'b1;
    endtask

    task automatic run_program();
        int cnt;
        load_program();
        pulse_reset();
        cnt = 0;
        while (!exit_o && cnt < 2000) begin
            @(negedge clk);
            cnt++;
        end
        if (!exit_o) begin
            errors++;
            $display("timeout: exit_o never rose, program did not reach ECALL");
        end
    endtask

    task automatic reset_test();
        int cnt;
        prog.delete();
        emit(ecall(), 0);
        load_program();
        arst_n_i = 1'b0;
        @(negedge clk);
        check_bit("exit_o", exit_o, 1'b0);
        check_bit("mem_req_o", mem_req_o, 1'b0);
        @(posedge clk);
        #2 arst_n_i = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!mem_req_o && cnt < 10) begin
            @(negedge clk);
            cnt++;
        end
        if (!mem_req_o) begin
            errors++;
            $display("timeout: no fetch request after reset");
        end
        check_word("mem_addr_o", mem_addr_o, RESET_PC);
        check_bit("mem_we_o", mem_we_o, 1'b0);
    endtask

    // gap of zero makes every dependency back to back
    task automatic alu_test(int gap);
        word_t a, b, c, s, d, n, o, x, t;
        int    sa, sb;
        a = rand_imm();
        b = rand_imm();
        c = rand_imm();
        s = a + b;
        d = a - b;
        n = s & d;
        o = s | a;
        x = n ^ o;
        sa = a;
        sb = b;
        t = (sa < sb) ? 32'd1 : 32'd0;
        prog.delete();
        emit(addi(1, 0, a), gap);
        emit(addi(2, 0, b), gap);
        emit(alu_r(0, 0, 4, 1, 2), gap);
        emit(alu_r(32, 0, 5, 1, 2), gap);
        emit(alu_r(0, 7, 6, 4, 5), gap);
        emit(alu_r(0, 6, 7, 4, 1), gap);
        emit(alu_r(0, 4, 8, 6, 7), gap);
        emit(alu_r(0, 2, 9, 1, 2), gap);
        emit(addi(10, 8, c), gap);
        emit(alu_r(0, 0, 3, 10, 9), gap);
        emit(ecall(), 4);
        run_program();
        check_word("gp_o", gp_o, x + c + t);
    endtask

    task automatic load_store_test();
        word_t v;
        v = rand_imm();
        prog.delete();
        emit(addi(1, 0, v), 0);
        emit(addi(2, 0, 512), 0);
        emit(sw(1, 2, 4), 0);
        emit(lw(3, 2, 4), 0);
        emit(ecall(), 4);
        run_program();
        check_word("gp_o", gp_o, v);
        check_word("mem[129]", mem[129], v);
    endtask

    // poisoned slots add 100 and 200 while the good path sums to 15
    task automatic branch_test();
        prog.delete();
        emit(addi(3, 0, 1), 0);
        emit(enc_b(8, 0, 0, 0), 0);
        emit(addi(3, 3, 100), 0);
        emit(addi(3, 3, 2), 0);
        emit(enc_b(8, 0, 0, 1), 0);
        emit(addi(3, 3, 4), 0);
        emit(enc_j(8, 0), 0);
        emit(addi(3, 3, 200), 0);
        emit(addi(3, 3, 8), 0);
        emit(ecall(), 4);
        run_program();
        check_word("gp_o", gp_o, 32'd15);
    endtask

    task automatic exit_hold_test();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_bit("exit_o", exit_o, 1'b1);
            check_bit("mem_req_o", mem_req_o, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'h1988));
        errors = 0;
        checks = 0;
        arst_n_i = 1'b0;
        mem_rdata_i = '0;
        reset_test();
        alu_test(3);
        alu_test(0);
        load_store_test();
        branch_test();
        exit_hold_test();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
hw/core_pkg.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/load_store_unit.sv
hw/mem_arbiter.sv
hw/pipeline_ctrl.sv
hw/core_top.sv
bench/tb_core_top.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_core_top -Mdir obj_dir &&
./obj_dir/Vtb_core_top | tee /dev/stderr | grep -qF '** PASS **' ||
{ echo "simulation failed"; exit 1; }
